// File: Makefile
SRCS := $(wildcard hdl/*.sv verif/*.sv)

.PHONY: run clean

obj_dir/Vtb_cpu: sources.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module tb_cpu \
		-f sources.f -o Vtb_cpu

run: obj_dir/Vtb_cpu verif/cpu_patterns.hex
	obj_dir/Vtb_cpu > sim.log 2>&1; cat sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: hdl/bus_port.sv
module bus_port (
    input  logic               CLK,
    input  logic               rst_n,
    input  logic               acc_start,
    input  logic               acc_we,
    input  cpu_bus_pkg::addr_t acc_addr,
    input  cpu_bus_pkg::data_t acc_wdata,
    output logic               acc_done,
    output cpu_bus_pkg::data_t acc_rdata,
    input  logic               mem_ack,
    input  cpu_bus_pkg::data_t mem_rdata,
    output logic               mem_req,
    output logic               mem_we,
    output cpu_bus_pkg::addr_t mem_addr,
    output cpu_bus_pkg::data_t mem_wdata
);
    localparam logic [1:0] BP_IDLE   = 2'd0;
    localparam logic [1:0] BP_ACK_HI = 2'd1;    // req up, waiting for ack
    localparam logic [1:0] BP_ACK_LO = 2'd2;    // req dropped, waiting for ack to fall

    logic [1:0] state;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state    <= BP_IDLE;
            mem_req  <= 1'b0;
            mem_we   <= 1'b0;
            acc_done <= 1'b0;
        end else begin
            acc_done <= 1'b0;
            case (state)
                BP_IDLE: begin
                    if (acc_start) begin
                        mem_req <= 1'b1;
                        mem_we  <= acc_we;
                        state   <= BP_ACK_HI;
                    end
                end
                BP_ACK_HI: begin
                    if (mem_ack) begin
                        mem_req <= 1'b0;
                        state   <= BP_ACK_LO;
                    end
                end
                BP_ACK_LO: begin
                    if (!mem_ack) begin    // handshake closed
                        mem_we   <= 1'b0;
                        acc_done <= 1'b1;
                        state    <= BP_IDLE;
                    end
                end
                default: state <= BP_IDLE;
            endcase
        end
    end

    // request payload, held for the whole handshake
    always_ff @(posedge CLK) begin
        if (state == BP_IDLE && acc_start) begin
            mem_addr  <= acc_addr;
            mem_wdata <= acc_wdata;
        end
        if (state == BP_ACK_HI && mem_ack) begin
            acc_rdata <= mem_rdata;    // valid only while ack is high
        end
    end

endmodule

// File: hdl/cpu_alu.sv
module cpu_alu (
    input  cpu_isa_pkg::alu_op_e alu_op,
    input  cpu_bus_pkg::data_t   a_in,
    input  cpu_bus_pkg::data_t   b_in,
    input  logic                 carry_in,
    output cpu_bus_pkg::data_t   result,
    output logic                 n,
    output logic                 z,
    output logic                 c
);
    import cpu_isa_pkg::*;

    logic [8:0] sum;    // 9th bit is carry out or borrow

    always_comb begin
        sum    = 9'd0;
        result = a_in;
        c      = carry_in;    // kept unless the op says otherwise
        case (alu_op)
            ALU_ADC: begin
                sum    = {1'b0, a_in} + {1'b0, b_in} + {8'd0, carry_in};
                result = sum[7:0];
                c      = sum[8];
            end
            ALU_AND: result = a_in & b_in;
            ALU_OR:  result = a_in | b_in;
            ALU_XOR: result = a_in ^ b_in;
            ALU_CMP: begin
                sum    = {1'b0, a_in} - {1'b0, b_in};
                result = sum[7:0];
                c      = ~sum[8];    // set when no borrow
            end
            ALU_INC: result = a_in + 8'd1;
            default: result = a_in;
        endcase
    end

    assign n = result[7];
    assign z = (result == 8'd0);

endmodule

// File: hdl/cpu_bus_pkg.sv
package cpu_bus_pkg;

    localparam int ADDR_W = 16;
    localparam int DATA_W = 8;

    typedef logic [ADDR_W-1:0] addr_t;    // memory address
    typedef logic [DATA_W-1:0] data_t;    // one data byte

    // where the start address lives, low byte first
    localparam addr_t RESET_VECTOR_DEFAULT = 16'hFFFC;

endpackage

// File: hdl/cpu_datapath.sv
module cpu_datapath (
    input  logic                 CLK,
    input  logic                 rst_n,
    input  cpu_bus_pkg::data_t   acc_rdata,
    input  logic                 pc_inc,
    input  logic                 pc_load,
    input  logic                 a_load,
    input  logic                 x_load,
    input  logic                 sr_load,
    input  logic                 carry_set,
    input  logic                 carry_clr,
    input  logic                 opr_lo_load,
    input  logic                 opr_hi_load,
    input  logic [2:0]           addr_sel,
    input  logic                 wdata_sel,
    input  cpu_isa_pkg::alu_op_e alu_op,
    input  logic [1:0]           alu_src,
    input  cpu_bus_pkg::addr_t   reset_vector,
    output cpu_bus_pkg::addr_t   acc_addr,
    output cpu_bus_pkg::data_t   acc_wdata,
    output logic                 flag_z,
    output logic                 flag_c
);
    import cpu_bus_pkg::*;
    import cpu_isa_pkg::*;

    data_t      a_reg;
    data_t      x_reg;
    data_t      opr_lo;
    data_t      opr_hi;
    data_t      alu_a;
    data_t      alu_result;
    addr_t      pc;
    logic [2:0] sr;    // {n, z, c}
    logic       alu_n;
    logic       alu_z;
    logic       alu_c;

    //////////////////////////////
    // address select, also the PC load source
    always_comb begin
        case (addr_sel)
            ASEL_ABS: acc_addr = {opr_hi, opr_lo};
            ASEL_ZP:  acc_addr = {8'h00, opr_lo};
            ASEL_VLO: acc_addr = reset_vector;
            ASEL_VHI: acc_addr = reset_vector + 16'd1;
            ASEL_REL: acc_addr = pc + {{8{opr_lo[7]}}, opr_lo};
            default:  acc_addr = pc;
        endcase
    end

    assign acc_wdata = (wdata_sel == WSEL_X) ? x_reg : a_reg;
    assign alu_a = (alu_src == SRC_X) ? x_reg : (alu_src == SRC_MEM) ? acc_rdata : a_reg;
    assign flag_z = sr[1];
    assign flag_c = sr[0];

    cpu_alu i_cpu_alu (
        .alu_op,
        .a_in     (alu_a),
        .b_in     (acc_rdata),
        .carry_in (sr[0]),
        .result   (alu_result),
        .n        (alu_n),
        .z        (alu_z),
        .c        (alu_c)
    );

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;    // stays zero until the vector load
            sr <= '0;
        end else begin
            if (pc_load) begin
                pc <= acc_addr;
            end else if (pc_inc) begin
                pc <= pc + 16'd1;
            end
            if (sr_load) begin
                sr <= {alu_n, alu_z, alu_c};
            end else if (carry_set) begin
                sr[0] <= 1'b1;
            end else if (carry_clr) begin
                sr[0] <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (a_load) begin
            a_reg <= alu_result;
        end
        if (x_load) begin
            x_reg <= alu_result;
        end
        if (opr_lo_load) begin
            opr_lo <= acc_rdata;
        end
        if (opr_hi_load) begin
            opr_hi <= acc_rdata;
        end
    end

endmodule

// File: hdl/cpu_isa_pkg.sv
package cpu_isa_pkg;

    //////////////////////////////
    // single-byte opcodes matched as a whole
    localparam logic [7:0] OP_TAX     = 8'hAA;
    localparam logic [7:0] OP_INX     = 8'hE8;
    localparam logic [7:0] OP_CLC     = 8'h18;
    localparam logic [7:0] OP_SEC     = 8'h38;
    localparam logic [7:0] OP_NOP     = 8'hEA;
    localparam logic [7:0] OP_JMP_ABS = 8'h4C;

    // opcode byte, seen raw or as aaa/bbb/cc
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [2:0] aaa;    // operation within group
            logic [2:0] bbb;    // addressing mode
            logic [1:0] cc;     // group
        } f;
    } opcode_u;

    typedef enum logic [2:0] {
        AM_IMPL,
        AM_IMM,
        AM_ZP,
        AM_ABS,
        AM_REL
    } addr_mode_e;

    typedef enum logic [4:0] {
        EX_LDA, EX_LDX, EX_STA, EX_STX,
        EX_ADC, EX_AND, EX_ORA, EX_EOR, EX_CMP,
        EX_TAX, EX_INX, EX_CLC, EX_SEC,
        EX_JMP, EX_BRANCH, EX_NOP, EX_ILLEGAL
    } exec_op_e;

    typedef enum logic [2:0] {
        ALU_PASS,
        ALU_ADC,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_CMP,     // a - b, flags only
        ALU_INC
    } alu_op_e;

    typedef enum logic {
        FLAG_C = 1'b0,
        FLAG_Z = 1'b1
    } flag_sel_e;

    //////////////////////////////
    // datapath select codes
    localparam logic [2:0] ASEL_PC  = 3'd0;
    localparam logic [2:0] ASEL_ABS = 3'd1;    // {opr_hi, opr_lo}
    localparam logic [2:0] ASEL_ZP  = 3'd2;    // {00, opr_lo}
    localparam logic [2:0] ASEL_VLO = 3'd3;
    localparam logic [2:0] ASEL_VHI = 3'd4;
    localparam logic [2:0] ASEL_REL = 3'd5;    // pc + signed offset

    localparam logic [1:0] SRC_A   = 2'd0;
    localparam logic [1:0] SRC_X   = 2'd1;
    localparam logic [1:0] SRC_MEM = 2'd2;

    localparam logic WSEL_A = 1'b0;
    localparam logic WSEL_X = 1'b1;

endpackage

// File: hdl/cpu_sequencer.sv
module cpu_sequencer #(
    parameter cpu_bus_pkg::addr_t RESET_VECTOR = cpu_bus_pkg::RESET_VECTOR_DEFAULT
) (
    input  logic                    CLK,
    input  logic                    rst_n,
    input  logic                    acc_done,
    input  cpu_isa_pkg::addr_mode_e addr_mode,
    input  cpu_isa_pkg::exec_op_e   exec_op,
    input  cpu_isa_pkg::flag_sel_e  branch_flag,
    input  logic                    branch_sense,
    input  logic                    flag_z,
    input  logic                    flag_c,
    output logic                    acc_start,
    output logic                    acc_we,
    output logic                    ir_load,
    output logic                    pc_inc,
    output logic                    pc_load,
    output logic                    a_load,
    output logic                    x_load,
    output logic                    sr_load,
    output logic                    carry_set,
    output logic                    carry_clr,
    output logic                    opr_lo_load,
    output logic                    opr_hi_load,
    output logic [2:0]              addr_sel,
    output logic                    wdata_sel,
    output cpu_isa_pkg::alu_op_e    alu_op,
    output logic [1:0]              alu_src,
    output cpu_bus_pkg::addr_t      reset_vector
);
    import cpu_isa_pkg::*;

    localparam logic [3:0] S_RESET   = 4'd0;
    localparam logic [3:0] S_VEC_LO  = 4'd1;
    localparam logic [3:0] S_VEC_HI  = 4'd2;
    localparam logic [3:0] S_VEC_JMP = 4'd3;
    localparam logic [3:0] S_FETCH   = 4'd4;
    localparam logic [3:0] S_DECODE  = 4'd5;
    localparam logic [3:0] S_OPR_LO  = 4'd6;
    localparam logic [3:0] S_OPR_HI  = 4'd7;
    localparam logic [3:0] S_DATA    = 4'd8;
    localparam logic [3:0] S_EXEC    = 4'd9;

    logic [3:0] state;
    logic [3:0] next_state;
    logic       busy;    // access issued, acc_done not yet seen
    logic       mem_state;
    logic       is_store;
    logic       taken;

    assign reset_vector = RESET_VECTOR;
    assign is_store  = (exec_op == EX_STA) || (exec_op == EX_STX);
    assign taken     = ((branch_flag == FLAG_Z) ? flag_z : flag_c) == branch_sense;
    assign mem_state = state inside {S_VEC_LO, S_VEC_HI, S_FETCH, S_OPR_LO, S_OPR_HI, S_DATA};
    assign acc_start = mem_state && !busy;
    assign acc_we    = acc_start && (state == S_DATA) && is_store;

    // operation-only decode, the load enables decide what sticks
    assign wdata_sel = (exec_op == EX_STX) ? WSEL_X : WSEL_A;
    always_comb begin
        alu_src = SRC_A;
        case (exec_op)
            EX_ADC:  alu_op = ALU_ADC;
            EX_AND:  alu_op = ALU_AND;
            EX_ORA:  alu_op = ALU_OR;
            EX_EOR:  alu_op = ALU_XOR;
            EX_CMP:  alu_op = ALU_CMP;
            EX_INX:  alu_op = ALU_INC;
            default: alu_op = ALU_PASS;
        endcase
        if (exec_op == EX_LDA || exec_op == EX_LDX) begin
            alu_src = SRC_MEM;
        end else if (exec_op == EX_INX) begin
            alu_src = SRC_X;
        end
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_RESET;
            busy  <= 1'b0;
        end else begin
            state <= next_state;
            if (acc_start) begin
                busy <= 1'b1;
            end else if (acc_done) begin
                busy <= 1'b0;
            end
        end
    end

    //////////////////////////////
    // next state and datapath strobes
    always_comb begin
        next_state  = state;
        ir_load     = 1'b0;
        pc_inc      = 1'b0;
        pc_load     = 1'b0;
        a_load      = 1'b0;
        x_load      = 1'b0;
        sr_load     = 1'b0;
        carry_set   = 1'b0;
        carry_clr   = 1'b0;
        opr_lo_load = 1'b0;
        opr_hi_load = 1'b0;
        addr_sel    = ASEL_PC;
        case (state)
            S_RESET: next_state = S_VEC_LO;
            S_VEC_LO: begin
                addr_sel    = ASEL_VLO;
                opr_lo_load = acc_done;
                next_state  = acc_done ? S_VEC_HI : S_VEC_LO;
            end
            S_VEC_HI: begin
                addr_sel    = ASEL_VHI;
                opr_hi_load = acc_done;
                next_state  = acc_done ? S_VEC_JMP : S_VEC_HI;
            end
            S_VEC_JMP: begin    // vector bytes -> PC
                addr_sel   = ASEL_ABS;
                pc_load    = 1'b1;
                next_state = S_FETCH;
            end
            S_FETCH: begin
                ir_load    = acc_done;
                pc_inc     = acc_done;
                next_state = acc_done ? S_DECODE : S_FETCH;
            end
            S_DECODE: next_state = (addr_mode == AM_IMPL) ? S_EXEC : S_OPR_LO;
            S_OPR_LO: begin
                opr_lo_load = acc_done;
                pc_inc      = acc_done;
                if (acc_done) begin
                    case (addr_mode)
                        AM_ABS:  next_state = S_OPR_HI;
                        AM_ZP:   next_state = S_DATA;
                        default: next_state = S_EXEC;    // imm and rel use the byte as is
                    endcase
                end
            end
            S_OPR_HI: begin
                opr_hi_load = acc_done;
                pc_inc      = acc_done;
                if (acc_done) begin
                    next_state = (exec_op == EX_JMP) ? S_EXEC : S_DATA;
                end
            end
            S_DATA: begin
                addr_sel = (addr_mode == AM_ZP) ? ASEL_ZP : ASEL_ABS;
                if (acc_done) begin
                    next_state = is_store ? S_FETCH : S_EXEC;
                end
            end
            S_EXEC: begin
                next_state = S_FETCH;
                case (exec_op)
                    EX_LDA, EX_ADC, EX_AND, EX_ORA, EX_EOR: begin
                        a_load  = 1'b1;
                        sr_load = 1'b1;
                    end
                    EX_LDX, EX_TAX, EX_INX: begin
                        x_load  = 1'b1;
                        sr_load = 1'b1;
                    end
                    EX_CMP: sr_load = 1'b1;
                    EX_CLC: carry_clr = 1'b1;
                    EX_SEC: carry_set = 1'b1;
                    EX_JMP: begin
                        addr_sel = ASEL_ABS;
                        pc_load  = 1'b1;
                    end
                    EX_BRANCH: begin
                        addr_sel = ASEL_REL;
                        pc_load  = taken;
                    end
                    default: ;    // NOP and illegal
                endcase
            end
            default: next_state = S_RESET;
        endcase
    end

endmodule

// File: hdl/cpu_top.sv
module cpu_top #(
    parameter cpu_bus_pkg::addr_t RESET_VECTOR = cpu_bus_pkg::RESET_VECTOR_DEFAULT
) (
    input  logic               CLK,
    input  logic               rst_n,
    input  logic               mem_ack,
    input  cpu_bus_pkg::data_t mem_rdata,
    output logic               mem_req,
    output logic               mem_we,
    output cpu_bus_pkg::addr_t mem_addr,
    output cpu_bus_pkg::data_t mem_wdata
);
    import cpu_bus_pkg::*;
    import cpu_isa_pkg::*;

    // bus side
    logic  acc_start;
    logic  acc_we;
    logic  acc_done;
    addr_t acc_addr;
    data_t acc_wdata;
    data_t acc_rdata;

    // decode results
    logic       ir_load;
    addr_mode_e addr_mode;
    exec_op_e   exec_op;
    flag_sel_e  branch_flag;
    logic       branch_sense;

    // datapath control and status
    logic       pc_inc;
    logic       pc_load;
    logic       a_load;
    logic       x_load;
    logic       sr_load;
    logic       carry_set;
    logic       carry_clr;
    logic       opr_lo_load;
    logic       opr_hi_load;
    logic [2:0] addr_sel;
    logic       wdata_sel;
    alu_op_e    alu_op;
    logic [1:0] alu_src;
    addr_t      reset_vector;
    logic       flag_z;
    logic       flag_c;

    bus_port i_bus_port (
        .CLK, .rst_n,
        .acc_start, .acc_we, .acc_addr, .acc_wdata, .acc_done, .acc_rdata,
        .mem_ack, .mem_rdata, .mem_req, .mem_we, .mem_addr, .mem_wdata
    );

    opcode_decoder i_opcode_decoder (
        .CLK, .rst_n,
        .ir_load,
        .opcode_in (acc_rdata),    // opcode byte straight off the bus
        .addr_mode, .exec_op, .branch_flag, .branch_sense
    );

    cpu_sequencer #(
        .RESET_VECTOR(RESET_VECTOR)
    ) i_cpu_sequencer (
        .CLK, .rst_n,
        .acc_done,
        .addr_mode, .exec_op, .branch_flag, .branch_sense,
        .flag_z, .flag_c,
        .acc_start, .acc_we, .ir_load,
        .pc_inc, .pc_load, .a_load, .x_load, .sr_load, .carry_set, .carry_clr,
        .opr_lo_load, .opr_hi_load, .addr_sel, .wdata_sel, .alu_op, .alu_src,
        .reset_vector
    );

    cpu_datapath i_cpu_datapath (
        .CLK, .rst_n,
        .acc_rdata,
        .pc_inc, .pc_load, .a_load, .x_load, .sr_load, .carry_set, .carry_clr,
        .opr_lo_load, .opr_hi_load, .addr_sel, .wdata_sel, .alu_op, .alu_src,
        .reset_vector,
        .acc_addr, .acc_wdata, .flag_z, .flag_c
    );

endmodule

// File: hdl/opcode_decoder.sv
module opcode_decoder (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  logic                   ir_load,
    input  cpu_bus_pkg::data_t     opcode_in,
    output cpu_isa_pkg::addr_mode_e addr_mode,
    output cpu_isa_pkg::exec_op_e   exec_op,
    output cpu_isa_pkg::flag_sel_e  branch_flag,
    output logic                   branch_sense
);
    import cpu_isa_pkg::*;

    opcode_u ir;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            ir.raw <= OP_NOP;
        end else if (ir_load) begin
            ir.raw <= opcode_in;
        end
    end

    // branch opcodes 1xy10000 with x picking C or Z and y the value that takes it
    assign branch_flag  = flag_sel_e'(ir.f.aaa[1]);
    assign branch_sense = ir.f.aaa[0];

    always_comb begin
        addr_mode = AM_IMPL;
        exec_op   = EX_ILLEGAL;
        case (ir.raw)
            OP_TAX: exec_op = EX_TAX;
            OP_INX: exec_op = EX_INX;
            OP_CLC: exec_op = EX_CLC;
            OP_SEC: exec_op = EX_SEC;
            OP_NOP: exec_op = EX_NOP;
            OP_JMP_ABS: begin
                addr_mode = AM_ABS;
                exec_op   = EX_JMP;
            end
            default: begin
                case (ir.f.cc)
                    2'b01: begin    // accumulator group
                        case (ir.f.bbb)
                            3'b001: addr_mode = AM_ZP;
                            3'b010: addr_mode = AM_IMM;
                            3'b011: addr_mode = AM_ABS;
                            default: addr_mode = AM_IMPL;
                        endcase
                        case (ir.f.aaa)
                            3'd0: exec_op = EX_ORA;
                            3'd1: exec_op = EX_AND;
                            3'd2: exec_op = EX_EOR;
                            3'd3: exec_op = EX_ADC;
                            3'd4: exec_op = EX_STA;
                            3'd5: exec_op = EX_LDA;
                            3'd6: exec_op = EX_CMP;
                            default: exec_op = EX_ILLEGAL;    // SBC not kept
                        endcase
                    end
                    2'b10: begin    // X group with only LDX and STX
                        case (ir.f.bbb)
                            3'b000: addr_mode = AM_IMM;
                            3'b001: addr_mode = AM_ZP;
                            3'b011: addr_mode = AM_ABS;
                            default: addr_mode = AM_IMPL;
                        endcase
                        if (ir.f.aaa == 3'd4) begin
                            exec_op = EX_STX;
                        end else if (ir.f.aaa == 3'd5) begin
                            exec_op = EX_LDX;
                        end
                    end
                    2'b00: begin
                        if (ir.f.bbb == 3'b100 && ir.f.aaa[2]) begin
                            addr_mode = AM_REL;
                            exec_op   = EX_BRANCH;
                        end
                    end
                    default: exec_op = EX_ILLEGAL;
                endcase
                // no store immediate and no mode outside the kept set
                if (addr_mode == AM_IMPL || (addr_mode == AM_IMM &&
                        (exec_op == EX_STA || exec_op == EX_STX))) begin
                    addr_mode = AM_IMPL;
                    exec_op   = EX_ILLEGAL;
                end
            end
        endcase
    end

endmodule

// File: sources.f
hdl/cpu_bus_pkg.sv
hdl/cpu_isa_pkg.sv
hdl/cpu_alu.sv
hdl/bus_port.sv
hdl/opcode_decoder.sv
hdl/cpu_sequencer.sv
hdl/cpu_datapath.sv
hdl/cpu_top.sv
verif/cpu_bus_asserts.sv
verif/tb_cpu.sv

// File: verif/cpu_bus_asserts.sv
module cpu_bus_asserts (
    input logic               CLK,
    input logic               rst_n,
    input logic               mem_req,
    input logic               mem_ack,
    input logic               mem_we,
    input cpu_bus_pkg::addr_t mem_addr
);
    timeunit 1ns;
    timeprecision 100ps;

    int req_fails     = 0;
    int payload_fails = 0;
    int ack_fails     = 0;

    // req held until ack comes
    req_until_ack: assert property (@(posedge CLK) disable iff (!rst_n)
        mem_req && !mem_ack |=> mem_req)
        else begin
            $error("mem_req fell before mem_ack rose");
            req_fails++;
        end

    req_payload_stable: assert property (@(posedge CLK) disable iff (!rst_n)
        mem_req |=> !mem_req || ($stable(mem_addr) && $stable(mem_we)))
        else begin
            $error("mem_addr or mem_we changed while mem_req was high");
            payload_fails++;
        end

    ack_needs_req: assert property (@(posedge CLK) disable iff (!rst_n)
        $rose(mem_ack) |-> mem_req)
        else begin
            $error("mem_ack rose without mem_req");
            ack_fails++;
        end

endmodule

bind bus_port cpu_bus_asserts i_cpu_bus_asserts (
    .CLK,
    .rst_n,
    .mem_req,
    .mem_ack,
    .mem_we,
    .mem_addr
);

// File: verif/cpu_patterns.hex
// program and data bytes at their addresses; the write list starts at @10000
// write list columns: test, address high, address low, data; test 00 ends the list
@0080
0F 33 F0
@0200
A9 5A 85 10
18 A9 10 69 25 85 11 38 A9 10 69 25 85 12
A9 F0 65 80 85 13 18 A9 F0 69 20 85 14 69 00 85 15
A9 F5 29 3C 85 16 25 81 85 17 09 05 85 18 05 82 85 19 49 FF 85 1A 45 81 85 1B
A9 7E AA 86 20 E8 86 21 A2 FF E8 86 22 E8 86 23 A2 C3 8E 00 03 8D 01 03
A2 AA A9 40 C9 40
F0 05 86 30 4C 64 02 85 30 D0 05 86 31 4C 6D 02 85 31
B0 05 86 32 4C 76 02 85 32 90 05 86 33 4C 7F 02 85 33 C9 50
90 05 86 34 4C 8A 02 85 34 D0 05 86 35 4C 93 02 85 35
F0 05 86 36 4C 9C 02 85 36 B0 05 86 37 4C A5 02 85 37 A9 00
F0 05 86 38 4C B0 02 85 38 A9 81 F0 05 86 39 4C BB 02 85 39
4C 00 04 A9 BD 85 40
@0400
A9 5C 85 41 4C 04 04
@FFFC
00 02
@10000
01 00 10 5A  02 00 11 35  02 00 12 36  02 00 13 FF  02 00 14 10  02 00 15 11
02 00 16 34  02 00 17 30  02 00 18 35  02 00 19 F5  02 00 1A 0A  02 00 1B 39
03 00 20 7E  03 00 21 7F  03 00 22 00  03 00 23 01  03 03 00 C3  03 03 01 7E
04 00 30 40  04 00 31 AA  04 00 32 40  04 00 33 AA  04 00 34 40  04 00 35 40
04 00 36 AA  04 00 37 AA  04 00 38 00  04 00 39 AA  05 00 41 5C  00 00 00 00

// File: verif/tb_cpu.sv
module tb_cpu;
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [16:0] LIST_BASE = 17'h10000;    // write list sits above the 64K image
    localparam logic [16:0] VEC_IX    = 17'h0FFFC;
    localparam logic [15:0] VEC_ADDR  = 16'hFFFC;

    logic        CLK;
    logic        rst_n;
    logic        mem_ack;
    logic [7:0]  mem_rdata;
    logic        mem_req;
    logic        mem_we;
    logic [15:0] mem_addr;
    logic [7:0]  mem_wdata;

    logic [7:0]  mem [0:131071];    // 64K image with the expected writes above it
    int          seed = 32'h36b9acdb;
    int          n_exp;
    int          wr_idx;
    int          read_count;
    int          access_count;
    int          extra_errors;
    int          cycles;
    int          limit;
    int          test_writes [0:255];
    int          test_errors [0:255];
    logic        all_written;

    cpu_top i_cpu_top (
        .CLK,
        .rst_n,
        .mem_ack,
        .mem_rdata,
        .mem_req,
        .mem_we,
        .mem_addr,
        .mem_wdata
    );

    always #10 CLK = ~CLK;

    //////////////////////////////
    // image load and write list size
    task automatic load_memory();
        logic [16:0] a;
        for (int i = 0; i < 131072; i++) begin
            a = 17'(i);
            mem[a] = a[15:8] ^ a[7:0] ^ {7'b0, a[16]};    // fill pattern from every address bit
        end
        $readmemh("verif/cpu_patterns.hex", mem);
        n_exp = 0;
        a = LIST_BASE;
        while (mem[a] != 8'h00) begin
            n_exp++;
            a = a + 17'd4;
        end
        limit = 40 * n_exp + 200;
    endtask

    function automatic string test_name(input logic [7:0] t);
        case (t)
            8'd1:    return "reset vector and first store";
            8'd2:    return "ADC AND ORA EOR";
            8'd3:    return "TAX INX STX";
            8'd4:    return "branches";
            8'd5:    return "JMP absolute";
            default: return "unknown";
        endcase
    endfunction

    task automatic report_test(input logic [7:0] t);
        $display("test %0d %s: %0d writes, %0d errors",
                 t, test_name(t), test_writes[t], test_errors[t]);
    endtask

    // first reads come from the vector and then from the address it holds
    task automatic check_read();
        logic [15:0] exp_addr;
        exp_addr = VEC_ADDR;
        if (read_count == 1) begin
            exp_addr = VEC_ADDR + 16'd1;
        end else if (read_count == 2) begin
            exp_addr = {mem[VEC_IX + 17'd1], mem[VEC_IX]};
        end
        if (read_count < 3) begin
            assert (mem_addr == exp_addr) else begin
                $display("ERR %0t mem_addr expected %h got %h", $time, exp_addr, mem_addr);
                test_errors[1]++;
            end
        end
        read_count++;
    endtask

    task automatic check_write();
        logic [16:0] ix;
        logic [7:0]  t;
        logic [15:0] exp_addr;
        logic [7:0]  exp_data;
        ix = 17'(LIST_BASE + 4 * wr_idx);
        t  = mem[ix];
        assert (t != 8'h00) else begin
            $display("unexpected write at %0t to %h with data %h after the last expected one",
                     $time, mem_addr, mem_wdata);
            extra_errors++;
        end
        if (t != 8'h00) begin
            exp_addr = {mem[ix + 17'd1], mem[ix + 17'd2]};
            exp_data = mem[ix + 17'd3];
            assert (mem_addr == exp_addr) else begin
                $display("ERR %0t mem_addr expected %h got %h", $time, exp_addr, mem_addr);
                test_errors[t]++;
            end
            assert (mem_wdata == exp_data) else begin
                $display("ERR %0t mem_wdata expected %h got %h", $time, exp_data, mem_wdata);
                test_errors[t]++;
            end
            test_writes[t]++;
            wr_idx++;
            if (mem[ix + 17'd4] != t) begin    // last write of this test
                report_test(t);
            end
            if (wr_idx == n_exp) begin
                all_written = 1'b1;
            end
        end
        mem[{1'b0, mem_addr}] = mem_wdata;
    endtask

    //////////////////////////////
    // memory model as a four-phase slave with random ack delay
    initial begin
        int delay;
        forever begin
            @(negedge CLK);
            if (rst_n && mem_req) begin
                delay = $random(seed) & 3;
                repeat (delay) @(negedge CLK);
                if (mem_we) begin
                    check_write();
                end else begin
                    check_read();
                    mem_rdata = mem[{1'b0, mem_addr}];
                end
                access_count++;
                mem_ack = 1'b1;
                while (mem_req) @(negedge CLK);    // master drops req first
                mem_ack = 1'b0;
            end
        end
    end

    // watchdog
    always @(posedge CLK) begin
        cycles++;
        if (cycles >= limit) begin
            $display("timeout after %0d cycles, test %0d stalled before write %0d of %0d",
                     cycles, mem[17'(LIST_BASE + 4 * wr_idx)], wr_idx + 1, n_exp);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        int total_errors;
        int bus_errors;
        CLK          = 1'b0;
        rst_n        = 1'b0;
        mem_ack      = 1'b0;
        mem_rdata    = 8'h00;
        all_written  = 1'b0;
        wr_idx       = 0;
        read_count   = 0;
        access_count = 0;
        extra_errors = 0;
        cycles       = 0;
        load_memory();
        repeat (2) @(negedge CLK);
        rst_n = 1'b1;

        wait (all_written);
        repeat (40) @(negedge CLK);    // catch any stray write after the last one
        bus_errors = i_cpu_top.i_bus_port.i_cpu_bus_asserts.req_fails
                   + i_cpu_top.i_bus_port.i_cpu_bus_asserts.payload_fails
                   + i_cpu_top.i_bus_port.i_cpu_bus_asserts.ack_fails;
        $display("test 6 random ack delay: %0d accesses served, %0d handshake errors",
                 access_count, bus_errors);

        total_errors = extra_errors + bus_errors;
        for (int t = 0; t < 256; t++) begin
            total_errors += test_errors[t];
        end
        $display("writes checked %0d of %0d, reads %0d, errors %0d",
                 wr_idx, n_exp, read_count, total_errors);
        if (total_errors == 0 && wr_idx == n_exp) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
